// File: verilog/cp0_defines.svh
// CP0 register addresses, Status and Cause field positions, exception codes and vector
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// ----------------------------------------------------------
// register positions, {rd, sel} with sel 0
// ----------------------------------------------------------
`define CP0_ADDR_BADVADDR 8'h40
`define CP0_ADDR_COUNT    8'h48
`define CP0_ADDR_COMPARE  8'h58
`define CP0_ADDR_STATUS   8'h60
`define CP0_ADDR_CAUSE    8'h68
`define CP0_ADDR_EPC      8'h70

// status fields
`define STATUS_IE    0
`define STATUS_EXL   1
`define STATUS_IM_HI 15
`define STATUS_IM_LO 8
`define STATUS_BEV   22

// cause fields
`define CAUSE_BD     31
`define CAUSE_TI     30
`define CAUSE_IP_HI  15
`define CAUSE_IP_LO  8
`define CAUSE_EXC_HI 6
`define CAUSE_EXC_LO 2

// ----------------------------------------------------------
// address-class exception codes
// ----------------------------------------------------------
`define EXC_MOD  5'd1
`define EXC_TLBL 5'd2
`define EXC_TLBS 5'd3
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5

`define EXC_VECTOR        32'hbfc0_0380
`define DELAY_SLOT_OFFSET 32'd4
`define EXT_INT_W         6

`endif

// File: verilog/cp0Pkg.sv
// shared CP0 types: data word, register position, exception code
`default_nettype none

package cp0Pkg;

    // ----------------------------------------------------------
    // data and address words
    // ----------------------------------------------------------
    typedef logic [31:0] word_t;

    // register number and select joined, {rd, sel}
    typedef logic [7:0] cp0Addr_t;

    // ----------------------------------------------------------
    // exception cause
    // ----------------------------------------------------------
    typedef logic [4:0] excCode_t;

endpackage

`default_nettype wire

// File: verilog/excSelect.sv
// oldest-stage exception selection and the exception-taken decision
`timescale 1ns/1ps
`default_nettype none

module excSelect (
    // exe stage
    input  wire                    exeHasExc_i,
    input  wire cp0Pkg::excCode_t  exeExcCode_i,
    input  wire                    exeIsDelaySlot_i,
    input  wire cp0Pkg::word_t     exeExcPc_i,
    input  wire cp0Pkg::word_t     exeBadVaddr_i,
    input  wire                    exeEret_i,
    // premem stage
    input  wire                    premHasExc_i,
    input  wire cp0Pkg::excCode_t  premExcCode_i,
    input  wire                    premIsDelaySlot_i,
    input  wire cp0Pkg::word_t     premExcPc_i,
    input  wire cp0Pkg::word_t     premBadVaddr_i,
    input  wire                    premEret_i,
    // mem stage
    input  wire                    memHasExc_i,
    input  wire cp0Pkg::excCode_t  memExcCode_i,
    input  wire                    memIsDelaySlot_i,
    input  wire cp0Pkg::word_t     memExcPc_i,
    input  wire cp0Pkg::word_t     memBadVaddr_i,
    input  wire                    memEret_i,
    // later stages still holding instructions
    input  wire                    premHasRisk_i,
    input  wire                    memHasRisk_i,
    input  wire                    wbHasRisk_i,
    input  wire                    statusExl_i,
    output logic                   takeExc_o,
    output cp0Pkg::excCode_t       excCode_o,
    output logic                   isDelaySlot_o,
    output cp0Pkg::word_t          excPc_o,
    output cp0Pkg::word_t          badVaddr_o,
    output logic                   eret_o
);

    logic selHasExc;

    // oldest stage wins: a stage is only eligible once everything after it is empty
    always_comb begin
        selHasExc     = 1'b0;
        excCode_o     = '0;
        isDelaySlot_o = 1'b0;
        excPc_o       = '0;
        badVaddr_o    = '0;
        eret_o        = 1'b0;
        if (!premHasRisk_i) begin
            selHasExc     = exeHasExc_i;
            excCode_o     = exeExcCode_i;
            isDelaySlot_o = exeIsDelaySlot_i;
            excPc_o       = exeExcPc_i;
            badVaddr_o    = exeBadVaddr_i;
            eret_o        = exeEret_i;
        end else if (!memHasRisk_i) begin
            selHasExc     = premHasExc_i;
            excCode_o     = premExcCode_i;
            isDelaySlot_o = premIsDelaySlot_i;
            excPc_o       = premExcPc_i;
            badVaddr_o    = premBadVaddr_i;
            eret_o        = premEret_i;
        end else if (!wbHasRisk_i) begin
            selHasExc     = memHasExc_i;
            excCode_o     = memExcCode_i;
            isDelaySlot_o = memIsDelaySlot_i;
            excPc_o       = memExcPc_i;
            badVaddr_o    = memBadVaddr_i;
            eret_o        = memEret_i;
        end
    end

    // nested exceptions are ignored while already in the handler
    assign takeExc_o = selHasExc && !statusExl_i;

endmodule

`default_nettype wire

// File: verilog/statusCause.sv
// Status and Cause registers with exception, eret, mtc0 and interrupt updates
`timescale 1ns/1ps
`default_nettype none
`include "cp0_defines.svh"

module statusCause (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          mtc0Wen_i,
    input  wire cp0Pkg::cp0Addr_t        cp0Addr_i,
    input  wire cp0Pkg::word_t           mtc0Data_i,
    input  wire                          takeExc_i,
    input  wire cp0Pkg::excCode_t        excCode_i,
    input  wire                          isDelaySlot_i,
    input  wire                          eret_i,
    input  wire                          timerHit_i,
    input  wire [`EXT_INT_W-1:0]         extInt_i,
    output cp0Pkg::word_t                status_o,
    output cp0Pkg::word_t                cause_o,
    output logic                         statusExl_o
);

    logic             statusIe;
    logic             statusExl;
    logic [7:0]       statusIm;
    logic             causeBd;
    logic             causeTi;
    logic [7:0]       causeIp;
    cp0Pkg::excCode_t causeExc;
    logic             statusWen;
    logic             causeWen;
    logic             compareWen;

    assign statusWen  = mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_STATUS);
    assign causeWen   = mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_CAUSE);
    assign compareWen = mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_COMPARE);

    // ----------------------------------------------------------
    // status
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            statusExl <= 1'b0;
        end else if (statusWen) begin
            statusExl <= mtc0Data_i[`STATUS_EXL];
        end else if (takeExc_i) begin
            statusExl <= 1'b1;
        end else if (eret_i) begin
            statusExl <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            statusIe <= 1'b0;
            statusIm <= '0;
        end else if (statusWen) begin
            statusIe <= mtc0Data_i[`STATUS_IE];
            statusIm <= mtc0Data_i[`STATUS_IM_HI:`STATUS_IM_LO];
        end
    end

    // ----------------------------------------------------------
    // cause
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            causeBd  <= 1'b0;
            causeExc <= '0;
        end else if (takeExc_i) begin
            causeBd  <= isDelaySlot_i;
            causeExc <= excCode_i;
        end
    end

    // compare write acknowledges the timer interrupt
    always_ff @(posedge clk) begin
        if (!rst) begin
            causeTi <= 1'b0;
        end else if (compareWen) begin
            causeTi <= 1'b0;
        end else if (timerHit_i) begin
            causeTi <= 1'b1;
        end
    end

    // hw lines sampled every cycle, ip7 shared with the timer
    always_ff @(posedge clk) begin
        if (!rst) begin
            causeIp <= '0;
        end else begin
            causeIp[7]   <= extInt_i[`EXT_INT_W-1] || causeTi;
            causeIp[6:2] <= extInt_i[4:0];
            if (causeWen) begin
                causeIp[1:0] <= mtc0Data_i[`CAUSE_IP_LO+1:`CAUSE_IP_LO];
            end
        end
    end

    always_comb begin
        status_o                                 = '0;
        status_o[`STATUS_BEV]                    = 1'b1;
        status_o[`STATUS_IM_HI:`STATUS_IM_LO]    = statusIm;
        status_o[`STATUS_EXL]                    = statusExl;
        status_o[`STATUS_IE]                     = statusIe;
        cause_o                                  = '0;
        cause_o[`CAUSE_BD]                       = causeBd;
        cause_o[`CAUSE_TI]                       = causeTi;
        cause_o[`CAUSE_IP_HI:`CAUSE_IP_LO]       = causeIp;
        cause_o[`CAUSE_EXC_HI:`CAUSE_EXC_LO]     = causeExc;
    end

    assign statusExl_o = statusExl;

endmodule

`default_nettype wire

// File: verilog/cp0Timer.sv
// Count and Compare registers with the timer match flag
`timescale 1ns/1ps
`default_nettype none
`include "cp0_defines.svh"

module cp0Timer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    mtc0Wen_i,
    input  wire cp0Pkg::cp0Addr_t  cp0Addr_i,
    input  wire cp0Pkg::word_t     mtc0Data_i,
    output cp0Pkg::word_t          count_o,
    output cp0Pkg::word_t          compare_o,
    output logic                   timerHit_o
);

    cp0Pkg::word_t count;
    cp0Pkg::word_t compare;
    logic          tick;

    // first edge after reset only arms the counter
    always_ff @(posedge clk) begin
        if (!rst) begin
            tick <= 1'b0;
        end else begin
            tick <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_COUNT)) begin
            count <= mtc0Data_i;
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            compare <= '0;
        end else if (mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_COMPARE)) begin
            compare <= mtc0Data_i;
        end
    end

    assign count_o    = count;
    assign compare_o  = compare;
    assign timerHit_o = (count == compare);

endmodule

`default_nettype wire

// File: verilog/epcBadVaddr.sv
// EPC and BadVAddr capture registers
`timescale 1ns/1ps
`default_nettype none
`include "cp0_defines.svh"

module epcBadVaddr (
    input  wire                    clk,
    input  wire                    mtc0Wen_i,
    input  wire cp0Pkg::cp0Addr_t  cp0Addr_i,
    input  wire cp0Pkg::word_t     mtc0Data_i,
    input  wire                    takeExc_i,
    input  wire cp0Pkg::excCode_t  excCode_i,
    input  wire                    isDelaySlot_i,
    input  wire cp0Pkg::word_t     excPc_i,
    input  wire cp0Pkg::word_t     badVaddr_i,
    output cp0Pkg::word_t          epc_o,
    output cp0Pkg::word_t          badVaddr_o
);

    cp0Pkg::word_t epc;
    cp0Pkg::word_t badVaddr;
    logic          addrClass;

    // codes that carry a faulting address
    assign addrClass = (excCode_i == `EXC_MOD)  || (excCode_i == `EXC_TLBL) ||
                       (excCode_i == `EXC_TLBS) || (excCode_i == `EXC_ADEL) ||
                       (excCode_i == `EXC_ADES);

    // delay-slot instructions restart at the branch
    always_ff @(posedge clk) begin
        if (takeExc_i) begin
            epc <= isDelaySlot_i ? (excPc_i - `DELAY_SLOT_OFFSET) : excPc_i;
        end else if (mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_EPC)) begin
            epc <= mtc0Data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (takeExc_i && addrClass) begin
            badVaddr <= badVaddr_i;
        end
    end

    assign epc_o      = epc;
    assign badVaddr_o = badVaddr;

endmodule

`default_nettype wire

// File: verilog/cp0Top.sv
// CP0 exception core top: submodules, mfc0 read mux and redirect outputs
`timescale 1ns/1ps
`default_nettype none
`include "cp0_defines.svh"

module cp0Top (
    input  wire                    clk,
    input  wire                    rst,
    // mtc0 / mfc0 from mem stage
    input  wire                    mtc0Wen_i,
    input  wire cp0Pkg::cp0Addr_t  cp0Addr_i,
    input  wire cp0Pkg::word_t     mtc0Data_i,
    input  wire                    exeHasExc_i,
    input  wire cp0Pkg::excCode_t  exeExcCode_i,
    input  wire                    exeIsDelaySlot_i,
    input  wire cp0Pkg::word_t     exeExcPc_i,
    input  wire cp0Pkg::word_t     exeBadVaddr_i,
    input  wire                    exeEret_i,
    input  wire                    premHasExc_i,
    input  wire cp0Pkg::excCode_t  premExcCode_i,
    input  wire                    premIsDelaySlot_i,
    input  wire cp0Pkg::word_t     premExcPc_i,
    input  wire cp0Pkg::word_t     premBadVaddr_i,
    input  wire                    premEret_i,
    input  wire                    memHasExc_i,
    input  wire cp0Pkg::excCode_t  memExcCode_i,
    input  wire                    memIsDelaySlot_i,
    input  wire cp0Pkg::word_t     memExcPc_i,
    input  wire cp0Pkg::word_t     memBadVaddr_i,
    input  wire                    memEret_i,
    input  wire                    premHasRisk_i,
    input  wire                    memHasRisk_i,
    input  wire                    wbHasRisk_i,
    input  wire [`EXT_INT_W-1:0]   extInt_i,
    output cp0Pkg::word_t          readData_o,
    output logic                   excOccur_o,
    output cp0Pkg::word_t          excDestPc_o,
    output cp0Pkg::word_t          status_o,
    output cp0Pkg::word_t          cause_o
);

    logic             takeExc;
    cp0Pkg::excCode_t selCode;
    logic             selDelaySlot;
    cp0Pkg::word_t    selPc;
    cp0Pkg::word_t    selBadVaddr;
    logic             selEret;
    logic             statusExl;
    logic             timerHit;
    cp0Pkg::word_t    countVal;
    cp0Pkg::word_t    compareVal;
    cp0Pkg::word_t    epcVal;
    cp0Pkg::word_t    badVaddrVal;
    cp0Pkg::word_t    statusVal;
    cp0Pkg::word_t    causeVal;

    excSelect i_excSelect (
        .exeHasExc_i(exeHasExc_i), .exeExcCode_i(exeExcCode_i),
        .exeIsDelaySlot_i(exeIsDelaySlot_i), .exeExcPc_i(exeExcPc_i),
        .exeBadVaddr_i(exeBadVaddr_i), .exeEret_i(exeEret_i),
        .premHasExc_i(premHasExc_i), .premExcCode_i(premExcCode_i),
        .premIsDelaySlot_i(premIsDelaySlot_i), .premExcPc_i(premExcPc_i),
        .premBadVaddr_i(premBadVaddr_i), .premEret_i(premEret_i),
        .memHasExc_i(memHasExc_i), .memExcCode_i(memExcCode_i),
        .memIsDelaySlot_i(memIsDelaySlot_i), .memExcPc_i(memExcPc_i),
        .memBadVaddr_i(memBadVaddr_i), .memEret_i(memEret_i),
        .premHasRisk_i(premHasRisk_i), .memHasRisk_i(memHasRisk_i),
        .wbHasRisk_i(wbHasRisk_i), .statusExl_i(statusExl),
        .takeExc_o(takeExc), .excCode_o(selCode), .isDelaySlot_o(selDelaySlot),
        .excPc_o(selPc), .badVaddr_o(selBadVaddr), .eret_o(selEret)
    );

    statusCause i_statusCause (
        .clk(clk), .rst(rst), .mtc0Wen_i(mtc0Wen_i), .cp0Addr_i(cp0Addr_i),
        .mtc0Data_i(mtc0Data_i), .takeExc_i(takeExc), .excCode_i(selCode),
        .isDelaySlot_i(selDelaySlot), .eret_i(selEret), .timerHit_i(timerHit),
        .extInt_i(extInt_i), .status_o(statusVal), .cause_o(causeVal),
        .statusExl_o(statusExl)
    );

    cp0Timer i_cp0Timer (
        .clk(clk), .rst(rst), .mtc0Wen_i(mtc0Wen_i), .cp0Addr_i(cp0Addr_i),
        .mtc0Data_i(mtc0Data_i), .count_o(countVal), .compare_o(compareVal),
        .timerHit_o(timerHit)
    );

    epcBadVaddr i_epcBadVaddr (
        .clk(clk), .mtc0Wen_i(mtc0Wen_i), .cp0Addr_i(cp0Addr_i),
        .mtc0Data_i(mtc0Data_i), .takeExc_i(takeExc), .excCode_i(selCode),
        .isDelaySlot_i(selDelaySlot), .excPc_i(selPc), .badVaddr_i(selBadVaddr),
        .epc_o(epcVal), .badVaddr_o(badVaddrVal)
    );

    // ----------------------------------------------------------
    // mfc0 read path
    // ----------------------------------------------------------
    always_comb begin
        case (cp0Addr_i)
            `CP0_ADDR_BADVADDR: readData_o = badVaddrVal;
            `CP0_ADDR_COUNT:    readData_o = countVal;
            `CP0_ADDR_COMPARE:  readData_o = compareVal;
            `CP0_ADDR_STATUS:   readData_o = statusVal;
            `CP0_ADDR_CAUSE:    readData_o = causeVal;
            `CP0_ADDR_EPC:      readData_o = epcVal;
            default:            readData_o = '0;
        endcase
    end

    // redirect: exception vector beats eret
    assign excOccur_o  = takeExc || selEret;
    assign excDestPc_o = takeExc ? `EXC_VECTOR : (selEret ? epcVal : '0);

    assign status_o = statusVal;
    assign cause_o  = causeVal;

endmodule

`default_nettype wire

// File: test/cp0_assert.sv
// concurrent checks on redirect, timer acknowledge and Status BEV bound to cp0Top
`timescale 1ns/1ps
`default_nettype none
`include "cp0_defines.svh"

module cp0Assert (
    input wire                    clk,
    input wire                    rst,
    input wire                    mtc0Wen_i,
    input wire cp0Pkg::cp0Addr_t  cp0Addr_i,
    input wire                    takeExc,
    input wire                    excOccur_o,
    input wire cp0Pkg::word_t     excDestPc_o,
    input wire cp0Pkg::word_t     readData_o,
    input wire cp0Pkg::word_t     status_o,
    input wire cp0Pkg::word_t     cause_o
);

    logic statusWrite;

    assign statusWrite = mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_STATUS);

    // a taken exception goes to the vector and enters the handler
    assert property (@(posedge clk) disable iff (!rst)
        (excOccur_o && takeExc && !statusWrite) |=>
            (($past(excDestPc_o) == `EXC_VECTOR) && status_o[`STATUS_EXL]))
        else $error("taken exception not at the vector or EXL not set");

    assert property (@(posedge clk) disable iff (!rst)
        (mtc0Wen_i && (cp0Addr_i == `CP0_ADDR_COMPARE)) |=> !cause_o[`CAUSE_TI])
        else $error("Cause TI still set after a Compare write");

    // BEV as seen through the mfc0 read path
    assert property (@(posedge clk)
        (cp0Addr_i == `CP0_ADDR_STATUS) |-> readData_o[`STATUS_BEV])
        else $error("Status BEV reads 0");

endmodule

bind cp0Top cp0Assert i_cp0Assert (
    .clk(clk), .rst(rst), .mtc0Wen_i(mtc0Wen_i), .cp0Addr_i(cp0Addr_i),
    .takeExc(takeExc), .excOccur_o(excOccur_o), .excDestPc_o(excDestPc_o),
    .readData_o(readData_o), .status_o(status_o), .cause_o(cause_o)
);

`default_nettype wire

// File: test/cp0Tb.sv
// CP0 testbench with stimulus table, checks and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "cp0_defines.svh"

module cp0Tb;

    typedef struct packed {
        logic             wen;
        cp0Pkg::cp0Addr_t wAddr;
        cp0Pkg::word_t    wData;
        logic [1:0]       stage;
        logic             hasExc;
        cp0Pkg::excCode_t code;
        logic             ds;
        cp0Pkg::word_t    pc;
        cp0Pkg::word_t    bva;
        logic             eret;
        logic [2:0]       risk;
        logic [5:0]       extInt;
        logic [7:0]       idle;
        cp0Pkg::cp0Addr_t rAddr;
        logic             expOccur;
        cp0Pkg::word_t    expDest;
        cp0Pkg::word_t    expRead;
        cp0Pkg::word_t    readMask;
    } step_t;

    localparam cp0Pkg::word_t maskAll   = 32'hffff_ffff;
    localparam cp0Pkg::word_t maskCause = 32'h8000_007c;
    localparam cp0Pkg::word_t maskExl   = 32'h0000_0002;
    localparam cp0Pkg::word_t maskTi    = 32'h4000_0000;
    localparam cp0Pkg::word_t maskTimer = 32'h4000_8000;
    localparam cp0Pkg::word_t maskIp    = 32'h0000_fc00;

    logic clk;
    logic rst;
    logic mtc0Wen;
    cp0Pkg::cp0Addr_t cp0Addr;
    cp0Pkg::word_t mtc0Data;
    logic exeHasExc, premHasExc, memHasExc;
    cp0Pkg::excCode_t exeExcCode, premExcCode, memExcCode;
    logic exeIsDelaySlot, premIsDelaySlot, memIsDelaySlot;
    cp0Pkg::word_t exeExcPc, premExcPc, memExcPc;
    cp0Pkg::word_t exeBadVaddr, premBadVaddr, memBadVaddr;
    logic exeEret, premEret, memEret;
    logic premHasRisk, memHasRisk, wbHasRisk;
    logic [`EXT_INT_W-1:0] extInt;
    cp0Pkg::word_t readData, excDestPc, status, cause;
    logic excOccur;
    step_t steps[$];
    int errors;
    int passed;
    longint limitNs;

    cp0Top i_dut (
        .clk(clk), .rst(rst), .mtc0Wen_i(mtc0Wen), .cp0Addr_i(cp0Addr), .mtc0Data_i(mtc0Data),
        .exeHasExc_i(exeHasExc), .exeExcCode_i(exeExcCode), .exeIsDelaySlot_i(exeIsDelaySlot),
        .exeExcPc_i(exeExcPc), .exeBadVaddr_i(exeBadVaddr), .exeEret_i(exeEret),
        .premHasExc_i(premHasExc), .premExcCode_i(premExcCode),
        .premIsDelaySlot_i(premIsDelaySlot), .premExcPc_i(premExcPc),
        .premBadVaddr_i(premBadVaddr), .premEret_i(premEret),
        .memHasExc_i(memHasExc), .memExcCode_i(memExcCode), .memIsDelaySlot_i(memIsDelaySlot),
        .memExcPc_i(memExcPc), .memBadVaddr_i(memBadVaddr), .memEret_i(memEret),
        .premHasRisk_i(premHasRisk), .memHasRisk_i(memHasRisk), .wbHasRisk_i(wbHasRisk),
        .extInt_i(extInt), .readData_o(readData), .excOccur_o(excOccur),
        .excDestPc_o(excDestPc), .status_o(status), .cause_o(cause)
    );

    always #5 clk = ~clk;

    // ----------------------------------------------------------
    // table row builders
    // ----------------------------------------------------------
    function automatic step_t readStep(input cp0Pkg::cp0Addr_t rAddr,
                                       input cp0Pkg::word_t expRead,
                                       input cp0Pkg::word_t mask);
        step_t s;
        s          = '0;
        s.stage    = 2'd3;
        s.risk     = 3'b111;
        s.rAddr    = rAddr;
        s.expRead  = expRead;
        s.readMask = mask;
        return s;
    endfunction

    function automatic step_t writeStep(input cp0Pkg::cp0Addr_t wAddr,
                                        input cp0Pkg::word_t wData,
                                        input cp0Pkg::cp0Addr_t rAddr,
                                        input cp0Pkg::word_t expRead,
                                        input cp0Pkg::word_t mask);
        step_t s;
        s       = readStep(rAddr, expRead, mask);
        s.wen   = 1'b1;
        s.wAddr = wAddr;
        s.wData = wData;
        return s;
    endfunction

    // hasExc low means the chosen stage carries an eret
    function automatic step_t excStep(input logic [1:0] stage, input logic hasExc,
                                      input cp0Pkg::excCode_t code, input logic ds,
                                      input cp0Pkg::word_t pc, input cp0Pkg::word_t bva,
                                      input logic expOccur, input cp0Pkg::word_t expDest,
                                      input cp0Pkg::cp0Addr_t rAddr,
                                      input cp0Pkg::word_t expRead,
                                      input cp0Pkg::word_t mask);
        step_t s;
        s          = readStep(rAddr, expRead, mask);
        s.stage    = stage;
        s.hasExc   = hasExc;
        s.eret     = !hasExc;
        s.code     = code;
        s.ds       = ds;
        s.pc       = pc;
        s.bva      = bva;
        s.expOccur = expOccur;
        s.expDest  = expDest;
        // risk bits {prem, mem, wb} leave only the chosen stage eligible
        s.risk     = (stage == 2'd0) ? 3'b011 : ((stage == 2'd1) ? 3'b101 : 3'b110);
        return s;
    endfunction

    task automatic buildTable();
        cp0Pkg::word_t cmpVal, stData, epcData, cntN;
        cp0Pkg::word_t pcA, bvA, pcB, bvB, pcC, bvC, pcD, bvD;
        logic [5:0] extVal;
        step_t s;
        cmpVal  = $urandom | 32'h8000_0000;
        stData  = $urandom & ~32'h2;
        epcData = $urandom;
        pcA     = $urandom & ~32'h3;
        bvA     = $urandom;
        pcB     = $urandom & ~32'h3;
        bvB     = $urandom;
        pcC     = $urandom & ~32'h3;
        bvC     = $urandom;
        pcD     = $urandom & ~32'h3;
        bvD     = $urandom;
        cntN    = $urandom & 32'h3fff_ffff;
        extVal  = 6'($urandom);
        steps.push_back(writeStep(`CP0_ADDR_COMPARE, cmpVal, `CP0_ADDR_COMPARE, cmpVal, maskAll));
        steps.push_back(writeStep(`CP0_ADDR_STATUS, stData, `CP0_ADDR_STATUS,
                                  (stData & 32'h0000_ff03) | 32'h0040_0000, maskAll));
        steps.push_back(writeStep(`CP0_ADDR_EPC, epcData, `CP0_ADDR_EPC, epcData, maskAll));
        // exe beats the decoys on premem and mem
        steps.push_back(excStep(2'd0, 1'b1, `EXC_ADEL, 1'b1, pcA, bvA, 1'b1, `EXC_VECTOR,
                                `CP0_ADDR_EPC, pcA - 32'd4, maskAll));
        steps.push_back(readStep(`CP0_ADDR_CAUSE, 32'h8000_0000 | (32'(`EXC_ADEL) << 2),
                                 maskCause));
        steps.push_back(readStep(`CP0_ADDR_BADVADDR, bvA, maskAll));
        // ignored while EXL is still set
        steps.push_back(excStep(2'd1, 1'b1, `EXC_ADES, 1'b0, pcB, bvB, 1'b0, 32'd0,
                                `CP0_ADDR_BADVADDR, bvA, maskAll));
        steps.push_back(excStep(2'd2, 1'b0, 5'd0, 1'b0, 32'd0, 32'd0, 1'b1, pcA - 32'd4,
                                `CP0_ADDR_STATUS, 32'd0, maskExl));
        // overflow carries no address
        steps.push_back(excStep(2'd0, 1'b1, 5'd12, 1'b0, pcC, bvC, 1'b1, `EXC_VECTOR,
                                `CP0_ADDR_BADVADDR, bvA, maskAll));
        steps.push_back(excStep(2'd0, 1'b0, 5'd0, 1'b0, 32'd0, 32'd0, 1'b1, pcC,
                                `CP0_ADDR_EPC, pcC, maskAll));
        steps.push_back(excStep(2'd2, 1'b1, `EXC_TLBS, 1'b0, pcD, bvD, 1'b1, `EXC_VECTOR,
                                `CP0_ADDR_BADVADDR, bvD, maskAll));
        steps.push_back(excStep(2'd1, 1'b0, 5'd0, 1'b0, 32'd0, 32'd0, 1'b1, pcD,
                                `CP0_ADDR_CAUSE, 32'(`EXC_TLBS) << 2, maskCause));
        steps.push_back(writeStep(`CP0_ADDR_COUNT, cntN, `CP0_ADDR_COMPARE, cmpVal, maskAll));
        s = writeStep(`CP0_ADDR_COMPARE, cntN + 32'd5, `CP0_ADDR_CAUSE, maskTimer, maskTimer);
        s.idle = 8'd10;
        steps.push_back(s);
        steps.push_back(writeStep(`CP0_ADDR_COMPARE, cntN + 32'h1000, `CP0_ADDR_CAUSE, 32'd0,
                                  maskTi));
        s = readStep(`CP0_ADDR_CAUSE, 32'(extVal) << 10, maskIp);
        s.extInt = extVal;
        s.idle   = 8'd1;
        steps.push_back(s);
        s = readStep(`CP0_ADDR_CAUSE, 32'(~extVal) << 10, maskIp);
        s.extInt = ~extVal;
        s.idle   = 8'd1;
        steps.push_back(s);
        steps.push_back(readStep(8'h08, 32'd0, maskAll));
    endtask

    // ----------------------------------------------------------
    // drive and check
    // ----------------------------------------------------------
    task automatic applyStep(input step_t s);
        mtc0Wen  <= s.wen;
        cp0Addr  <= s.wen ? s.wAddr : s.rAddr;
        mtc0Data <= s.wData;
        {premHasRisk, memHasRisk, wbHasRisk} <= s.risk;
        extInt   <= s.extInt;
        // losing stages hold decoy exceptions with inverted fields
        exeHasExc       <= (s.stage == 2'd0) ? s.hasExc : (s.stage != 2'd3);
        exeEret         <= (s.stage == 2'd0) && s.eret;
        exeExcCode      <= (s.stage == 2'd0) ? s.code : 5'd12;
        exeIsDelaySlot  <= (s.stage == 2'd0) ? s.ds : !s.ds;
        exeExcPc        <= (s.stage == 2'd0) ? s.pc : ~s.pc;
        exeBadVaddr     <= (s.stage == 2'd0) ? s.bva : ~s.bva;
        premHasExc      <= (s.stage == 2'd1) ? s.hasExc : (s.stage != 2'd3);
        premEret        <= (s.stage == 2'd1) && s.eret;
        premExcCode     <= (s.stage == 2'd1) ? s.code : 5'd12;
        premIsDelaySlot <= (s.stage == 2'd1) ? s.ds : !s.ds;
        premExcPc       <= (s.stage == 2'd1) ? s.pc : ~s.pc;
        premBadVaddr    <= (s.stage == 2'd1) ? s.bva : ~s.bva;
        memHasExc       <= (s.stage == 2'd2) ? s.hasExc : (s.stage != 2'd3);
        memEret         <= (s.stage == 2'd2) && s.eret;
        memExcCode      <= (s.stage == 2'd2) ? s.code : 5'd12;
        memIsDelaySlot  <= (s.stage == 2'd2) ? s.ds : !s.ds;
        memExcPc        <= (s.stage == 2'd2) ? s.pc : ~s.pc;
        memBadVaddr     <= (s.stage == 2'd2) ? s.bva : ~s.bva;
    endtask

    task automatic clearStrobes(input cp0Pkg::cp0Addr_t rAddr);
        mtc0Wen    <= 1'b0;
        cp0Addr    <= rAddr;
        exeHasExc  <= 1'b0;
        premHasExc <= 1'b0;
        memHasExc  <= 1'b0;
        exeEret    <= 1'b0;
        premEret   <= 1'b0;
        memEret    <= 1'b0;
    endtask

    task automatic reportMismatch(input string name, input cp0Pkg::word_t expVal,
                                  input cp0Pkg::word_t gotVal);
        $display("ERROR t=%0t %s expected=%h got=%h", $time, name, expVal, gotVal);
        errors++;
    endtask

    // watchdog armed once the table length is known
    initial begin
        wait (limitNs != 0);
        #(limitNs);
        $display("watchdog expired before all steps finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        step_t s;
        int stepErrs;
        longint cycles;
        void'($urandom(32'hbcad_7e1b));
        clk = 1'b0;
        rst = 1'b0;
        mtc0Wen = 1'b0;
        cp0Addr = '0;
        mtc0Data = '0;
        {exeHasExc, premHasExc, memHasExc, exeEret, premEret, memEret} = '0;
        {exeExcCode, premExcCode, memExcCode} = '0;
        {exeIsDelaySlot, premIsDelaySlot, memIsDelaySlot} = '0;
        {exeExcPc, premExcPc, memExcPc, exeBadVaddr, premBadVaddr, memBadVaddr} = '0;
        {premHasRisk, memHasRisk, wbHasRisk} = 3'b111;
        extInt = '0;
        errors = 0;
        passed = 0;
        limitNs = 0;
        buildTable();
        cycles = 4;
        foreach (steps[i]) cycles += longint'(steps[i].idle) + 3;
        limitNs = 2 * cycles * 10;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            stepErrs = errors;
            @(posedge clk);
            applyStep(s);
            // redirect is combinational in the drive cycle
            @(negedge clk);
            if (excOccur !== s.expOccur) begin
                reportMismatch("excOccur_o", 32'(s.expOccur), 32'(excOccur));
            end
            if (excDestPc !== s.expDest) begin
                reportMismatch("excDestPc_o", s.expDest, excDestPc);
            end
            @(posedge clk);
            clearStrobes(s.rAddr);
            repeat (s.idle) @(posedge clk);
            @(negedge clk);
            if ((readData & s.readMask) !== (s.expRead & s.readMask)) begin
                reportMismatch("readData_o", s.expRead & s.readMask, readData & s.readMask);
            end
            if ((s.rAddr == `CP0_ADDR_STATUS) &&
                ((status & s.readMask) !== (s.expRead & s.readMask))) begin
                reportMismatch("status_o", s.expRead & s.readMask, status & s.readMask);
            end
            if ((s.rAddr == `CP0_ADDR_CAUSE) &&
                ((cause & s.readMask) !== (s.expRead & s.readMask))) begin
                reportMismatch("cause_o", s.expRead & s.readMask, cause & s.readMask);
            end
            if (errors == stepErrs) begin
                passed++;
                $display("step %0d passed", i);
            end else begin
                $display("step %0d failed", i);
            end
        end
        $display("%0d steps, %0d passed, %0d errors", steps.size(), passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/cp0Pkg.sv
verilog/excSelect.sv
verilog/statusCause.sv
verilog/cp0Timer.sv
verilog/epcBadVaddr.sv
verilog/cp0Top.sv
test/cp0_assert.sv
test/cp0Tb.sv

// File: run.sh
#!/bin/bash
# build and run the CP0 testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cp0Tb -f all.f -o cp0Sim
./obj_dir/cp0Sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
